//--- src/game_rules_pkg.sv
`default_nettype none

package game_rules_pkg;

	localparam int NUM_PLAYERS = 4;
	localparam int BOARD_SPOTS = 32;

	typedef logic [1:0] player_t;
	// position on the ring, wraps past 31
	typedef logic [4:0] spot_t;
	typedef logic [2:0] die_t;
	typedef logic [12:0] score_t;
	// one bit per spot, set once the property is owned
	typedef logic [BOARD_SPOTS-1:0] progress_t;

	// base value per spot
	localparam logic [8:0] SPOT_SCORE [BOARD_SPOTS] = '{
		9'd0,   9'd5,   9'd0,   9'd15,  9'd0,   9'd15,  9'd10,  9'd20,
		9'd0,   9'd20,  9'd30,  9'd30,  9'd0,   9'd40,  9'd40,  9'd50,
		9'd150, 9'd40,  9'd40,  9'd40,  9'd0,   9'd10,  9'd60,  9'd60,
		9'd300, 9'd10,  9'd30,  9'd60,  9'd0,   9'd80,  9'd0,   9'd80
	};

	// spot classes as masks over the ring
	localparam progress_t PROPERTY_MASK = 32'hafef_eeea;
	localparam progress_t PENALTY_SPOTS = 32'h4000_0004;
	localparam progress_t BONUS_SPOTS   = 32'h1010_1010;
	localparam progress_t NEUTRAL_SPOTS = 32'h0000_0101;
	// no die multiplier on these
	localparam progress_t FLAT_SPOTS    = 32'h0101_0000;

	localparam logic [8:0] PENALTY_BASE = 9'd20;
	localparam logic [8:0] BONUS_BASE   = 9'd20;

endpackage

`default_nettype wire

//--- src/game_ctrl_pkg.sv
`default_nettype none

package game_ctrl_pkg;

	typedef enum logic [2:0] {
		IDLE,
		ROLL,
		STEP,
		STOP,
		REPORT,
		NEXT,
		OVER
	} ctrl_state_t;

	// cycles per board step
	localparam int STEP_CYCLES      = 16;
	localparam int FAST_STEP_CYCLES = 2;

	// wide enough for STEP_CYCLES - 1
	typedef logic [3:0] step_cnt_t;

	// reports the consumer can hold
	localparam int REPORT_CREDITS = 2;
	typedef logic [1:0] credit_t;

	// dice sum, at most 12
	typedef logic [3:0] move_cnt_t;

endpackage

`default_nettype wire

//--- src/step_timer.sv
`default_nettype none
`timescale 1ns/1ps

module step_timer (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic fast,
	input  logic run,
	output logic tick
);

	game_ctrl_pkg::step_cnt_t cnt;
	game_ctrl_pkg::step_cnt_t last;
	logic                     fast_q;

	// rate is fixed for the whole move
	assign last = fast_q ? game_ctrl_pkg::step_cnt_t'(game_ctrl_pkg::FAST_STEP_CYCLES - 1)
	                     : game_ctrl_pkg::step_cnt_t'(game_ctrl_pkg::STEP_CYCLES - 1);

	assign tick = run && !start && (cnt == last);

	always_ff @(posedge clk) begin
		if (!reset) begin
			cnt    <= '0;
			fast_q <= 1'b0;
		end else if (start) begin
			cnt    <= '0;
			fast_q <= fast;
		end else if (run) begin
			// wrap at the end of each period
			if (tick)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- src/player_bank.sv
`default_nettype none
`timescale 1ns/1ps

module player_bank #(
	parameter type entry_t = logic
) (
	input  logic                     clk,
	input  logic                     reset,
	input  game_rules_pkg::player_t  index,
	input  logic                     wr_en,
	input  entry_t                   wr_data,
	output entry_t                   rd_data
);

	entry_t mem [game_rules_pkg::NUM_PLAYERS];

	// game state starts from zero for every player
	always_ff @(posedge clk) begin
		if (!reset) begin
			for (int i = 0; i < game_rules_pkg::NUM_PLAYERS; i++)
				mem[i] <= '0;
		end else if (wr_en) begin
			mem[index] <= wr_data;
		end
	end

	// read is combinational at the current player
	assign rd_data = mem[index];

endmodule

`default_nettype wire

//--- src/score_calc.sv
`default_nettype none
`timescale 1ns/1ps

module score_calc (
	input  game_rules_pkg::spot_t     spot,
	input  game_rules_pkg::score_t    score,
	input  game_rules_pkg::progress_t progress,
	input  game_rules_pkg::die_t      d1,
	input  game_rules_pkg::die_t      d2,
	output game_rules_pkg::score_t    new_score,
	output game_rules_pkg::progress_t new_progress,
	output logic                      all_owned
);

	// largest change is 80 * 6
	typedef logic [11:0] delta_t;

	game_rules_pkg::die_t larger;
	delta_t               add;
	delta_t               sub;
	logic [13:0]          sum;

	assign larger = (d1 > d2) ? d1 : d2;

	always_comb begin
		add          = '0;
		sub          = '0;
		new_progress = progress;
		if (game_rules_pkg::PENALTY_SPOTS[spot]) begin
			sub = delta_t'(larger) * delta_t'(game_rules_pkg::PENALTY_BASE);
		end else if (game_rules_pkg::BONUS_SPOTS[spot]) begin
			add = delta_t'(larger) * delta_t'(game_rules_pkg::BONUS_BASE);
		end else if (game_rules_pkg::NEUTRAL_SPOTS[spot]) begin
			add = '0;
		end else if (game_rules_pkg::PROPERTY_MASK[spot] && !progress[spot]) begin
			// first visit buys the property
			new_progress[spot] = 1'b1;
			if (game_rules_pkg::FLAT_SPOTS[spot])
				add = delta_t'(game_rules_pkg::SPOT_SCORE[spot]);
			else
				add = delta_t'(game_rules_pkg::SPOT_SCORE[spot]) * delta_t'(larger);
		end
	end

	assign sum = {1'b0, score} + 14'(add);

	// clamp at zero going down, saturate going up
	always_comb begin
		if (sub != '0)
			new_score = (score > 13'(sub)) ? score - 13'(sub) : '0;
		else
			new_score = sum[13] ? '1 : sum[12:0];
	end

	assign all_owned = &(new_progress | ~game_rules_pkg::PROPERTY_MASK);

endmodule

`default_nettype wire

//--- src/turn_reporter.sv
`default_nettype none
`timescale 1ns/1ps

module turn_reporter (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     send,
	input  game_rules_pkg::player_t  player,
	input  game_rules_pkg::spot_t    spot,
	input  game_rules_pkg::score_t   score,
	input  logic                     credit_return,
	output logic                     can_send,
	output logic                     report_valid,
	output game_rules_pkg::player_t  report_player,
	output game_rules_pkg::spot_t    report_spot,
	output game_rules_pkg::score_t   report_score
);

	game_ctrl_pkg::credit_t credits;

	assign can_send = (credits != '0);

	always_ff @(posedge clk) begin
		if (!reset) begin
			credits      <= game_ctrl_pkg::credit_t'(game_ctrl_pkg::REPORT_CREDITS);
			report_valid <= 1'b0;
		end else begin
			report_valid <= send;
			// spend and return may land together
			case ({send, credit_return})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// report fields, valid alongside report_valid
	always_ff @(posedge clk) begin
		if (send) begin
			report_player <= player;
			report_spot   <= spot;
			report_score  <= score;
		end
	end

endmodule

`default_nettype wire

//--- src/game_fsm.sv
`default_nettype none
`timescale 1ns/1ps

module game_fsm (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     roll,
	input  game_rules_pkg::die_t     d1,
	input  game_rules_pkg::die_t     d2,
	input  logic                     fast_fwd,
	input  logic                     step_tick,
	input  logic                     all_owned,
	input  logic                     can_send,
	input  game_rules_pkg::spot_t    spot,
	output logic                     timer_start,
	output logic                     timer_run,
	output game_rules_pkg::player_t  player,
	output logic                     spot_wr,
	output logic                     score_wr,
	output logic                     progress_wr,
	output game_rules_pkg::spot_t    next_spot,
	output game_rules_pkg::die_t     dice_d1,
	output game_rules_pkg::die_t     dice_d2,
	output logic                     send,
	output logic                     roll_ready,
	output logic                     game_over
);

	game_ctrl_pkg::ctrl_state_t         state;
	game_ctrl_pkg::move_cnt_t           moves_left;
	logic [game_rules_pkg::NUM_PLAYERS-1:0] finished;
	logic                               turn_fast;
	logic                               accept;
	game_rules_pkg::player_t            next_player;
	game_rules_pkg::player_t            cand;

	assign roll_ready  = (state == game_ctrl_pkg::ROLL);
	assign game_over   = (state == game_ctrl_pkg::OVER);
	assign accept      = roll && roll_ready;

	// timer is armed on the roll, counts only while walking
	assign timer_start = accept;
	assign timer_run   = (state == game_ctrl_pkg::STEP);

	assign spot_wr     = (state == game_ctrl_pkg::STEP) && step_tick;
	assign next_spot   = spot + 1'b1;
	assign score_wr    = (state == game_ctrl_pkg::STOP);
	assign progress_wr = (state == game_ctrl_pkg::STOP);
	assign send        = (state == game_ctrl_pkg::REPORT) && can_send;

	// pick who plays next
	always_comb begin
		cand        = '0;
		next_player = player;
		if (!(dice_d1 == dice_d2 && !finished[player])) begin
			// nearest unfinished player wins, self if nobody else is left
			for (int i = game_rules_pkg::NUM_PLAYERS - 1; i > 0; i--) begin
				cand = player + game_rules_pkg::player_t'(i);
				if (!finished[cand])
					next_player = cand;
			end
		end
	end

	// dice held for the whole turn
	always_ff @(posedge clk) begin
		if (accept) begin
			dice_d1 <= d1;
			dice_d2 <= d2;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			state      <= game_ctrl_pkg::IDLE;
			player     <= '0;
			finished   <= '0;
			moves_left <= '0;
			turn_fast  <= 1'b0;
		end else begin
			case (state)
				game_ctrl_pkg::IDLE: state <= game_ctrl_pkg::ROLL;
				game_ctrl_pkg::ROLL: begin
					if (accept) begin
						moves_left <= game_ctrl_pkg::move_cnt_t'(d1)
						            + game_ctrl_pkg::move_cnt_t'(d2);
						turn_fast  <= fast_fwd;
						state      <= game_ctrl_pkg::STEP;
					end
				end
				game_ctrl_pkg::STEP: begin
					if (step_tick) begin
						moves_left <= moves_left - 1'b1;
						if (moves_left == 4'd1)
							state <= game_ctrl_pkg::STOP;
					end
				end
				game_ctrl_pkg::STOP: begin
					if (all_owned)
						finished[player] <= 1'b1;
					state <= game_ctrl_pkg::REPORT;
				end
				// hold here until the consumer has room
				game_ctrl_pkg::REPORT: begin
					if (can_send)
						state <= game_ctrl_pkg::NEXT;
				end
				game_ctrl_pkg::NEXT: begin
					if (&finished) begin
						state <= game_ctrl_pkg::OVER;
					end else begin
						player <= next_player;
						// fast forward goes straight back to the roll
						state  <= turn_fast ? game_ctrl_pkg::ROLL : game_ctrl_pkg::IDLE;
					end
				end
				game_ctrl_pkg::OVER: state <= game_ctrl_pkg::OVER;
				default: state <= game_ctrl_pkg::IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/board_game_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module board_game_ctrl (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     roll,
	input  game_rules_pkg::die_t     d1,
	input  game_rules_pkg::die_t     d2,
	input  logic                     fast_fwd,
	input  logic                     credit_return,
	output logic                     roll_ready,
	output game_rules_pkg::player_t  turn_player,
	output logic                     game_over,
	output logic                     report_valid,
	output game_rules_pkg::player_t  report_player,
	output game_rules_pkg::spot_t    report_spot,
	output game_rules_pkg::score_t   report_score
);

	logic                      timer_start;
	logic                      timer_run;
	logic                      step_tick;
	logic                      spot_wr;
	logic                      score_wr;
	logic                      progress_wr;
	logic                      all_owned;
	logic                      send;
	logic                      can_send;
	game_rules_pkg::spot_t     cur_spot;
	game_rules_pkg::spot_t     next_spot;
	game_rules_pkg::score_t    cur_score;
	game_rules_pkg::score_t    new_score;
	game_rules_pkg::progress_t cur_progress;
	game_rules_pkg::progress_t new_progress;
	game_rules_pkg::die_t      dice_d1;
	game_rules_pkg::die_t      dice_d2;

	game_fsm u_game_fsm (
		.clk         (clk),
		.reset       (reset),
		.roll        (roll),
		.d1          (d1),
		.d2          (d2),
		.fast_fwd    (fast_fwd),
		.step_tick   (step_tick),
		.all_owned   (all_owned),
		.can_send    (can_send),
		.spot        (cur_spot),
		.timer_start (timer_start),
		.timer_run   (timer_run),
		.player      (turn_player),
		.spot_wr     (spot_wr),
		.score_wr    (score_wr),
		.progress_wr (progress_wr),
		.next_spot   (next_spot),
		.dice_d1     (dice_d1),
		.dice_d2     (dice_d2),
		.send        (send),
		.roll_ready  (roll_ready),
		.game_over   (game_over)
	);

	step_timer u_step_timer (
		.clk   (clk),
		.reset (reset),
		.start (timer_start),
		.fast  (fast_fwd),
		.run   (timer_run),
		.tick  (step_tick)
	);

	player_bank #(.entry_t(game_rules_pkg::spot_t)) u_spot_bank (
		.clk     (clk),
		.reset   (reset),
		.index   (turn_player),
		.wr_en   (spot_wr),
		.wr_data (next_spot),
		.rd_data (cur_spot)
	);

	player_bank #(.entry_t(game_rules_pkg::score_t)) u_score_bank (
		.clk     (clk),
		.reset   (reset),
		.index   (turn_player),
		.wr_en   (score_wr),
		.wr_data (new_score),
		.rd_data (cur_score)
	);

	player_bank #(.entry_t(game_rules_pkg::progress_t)) u_progress_bank (
		.clk     (clk),
		.reset   (reset),
		.index   (turn_player),
		.wr_en   (progress_wr),
		.wr_data (new_progress),
		.rd_data (cur_progress)
	);

	score_calc u_score_calc (
		.spot         (cur_spot),
		.score        (cur_score),
		.progress     (cur_progress),
		.d1           (dice_d1),
		.d2           (dice_d2),
		.new_score    (new_score),
		.new_progress (new_progress),
		.all_owned    (all_owned)
	);

	turn_reporter u_turn_reporter (
		.clk           (clk),
		.reset         (reset),
		.send          (send),
		.player        (turn_player),
		.spot          (cur_spot),
		.score         (cur_score),
		.credit_return (credit_return),
		.can_send      (can_send),
		.report_valid  (report_valid),
		.report_player (report_player),
		.report_spot   (report_spot),
		.report_score  (report_score)
	);

endmodule

`default_nettype wire

//--- dv/turn_reporter_asserts.sv
`default_nettype none
`timescale 1ns/1ps

module turn_reporter_asserts (
	input logic                   clk,
	input logic                   reset,
	input logic                   send,
	input logic                   can_send,
	input logic                   credit_return,
	input logic                   report_valid,
	input game_ctrl_pkg::credit_t credits
);

	// never more credit than the consumer can buffer
	a_credit_limit: assert property (
		@(posedge clk) disable iff (!reset)
		credits <= game_ctrl_pkg::credit_t'(game_ctrl_pkg::REPORT_CREDITS)
	) else $error("credit count above the consumer buffer size");

	// a send spends exactly one credit that was there to spend
	a_send_needs_credit: assert property (
		@(posedge clk) disable iff (!reset)
		(send && !credit_return) |=>
			(credits == game_ctrl_pkg::credit_t'($past(credits) - 1'b1)) && ($past(credits) != '0)
	) else $error("send raised with no credit left");

	// one pulse per report
	a_single_pulse: assert property (
		@(posedge clk) disable iff (!reset)
		report_valid |=> !report_valid
	) else $error("report_valid high on two cycles in a row");

endmodule

`default_nettype wire

//--- dv/tb_board_game.sv
`default_nettype none
`timescale 1ns/1ps

module tb_board_game;

	localparam int MAX_TURNS  = 6000;
	localparam int WAIT_LIMIT = 2000;
	localparam int SCORE_MAX  = 8191;
	localparam int NP         = game_rules_pkg::NUM_PLAYERS;

	logic                    clk;
	logic                    reset;
	logic                    roll;
	game_rules_pkg::die_t    d1;
	game_rules_pkg::die_t    d2;
	logic                    fast_fwd;
	logic                    credit_return;
	logic                    roll_ready;
	game_rules_pkg::player_t turn_player;
	logic                    game_over;
	logic                    report_valid;
	game_rules_pkg::player_t report_player;
	game_rules_pkg::spot_t   report_spot;
	game_rules_pkg::score_t  report_score;

	// reference model of every player
	int          m_spot [NP];
	int          m_score [NP];
	logic [31:0] m_prog [NP];
	logic        m_fin [NP];
	int          m_player;
	logic [31:0] prop_mask;

	// expected reports, oldest first
	int          exp_player[$];
	int          exp_spot[$];
	int          exp_score[$];
	// cycle at which each held report gives its credit back
	int          credit_due[$];

	logic [31:0] rng_state;
	int          cycle;
	int          errors;
	int          checks;
	int          timeouts;
	int          rpt_count;
	int          rpt_cycle;
	int          outstanding;
	logic        turn_open;
	logic        last_valid;

	board_game_ctrl u_board_game_ctrl (
		.clk           (clk),
		.reset         (reset),
		.roll          (roll),
		.d1            (d1),
		.d2            (d2),
		.fast_fwd      (fast_fwd),
		.credit_return (credit_return),
		.roll_ready    (roll_ready),
		.turn_player   (turn_player),
		.game_over     (game_over),
		.report_valid  (report_valid),
		.report_player (report_player),
		.report_spot   (report_spot),
		.report_score  (report_score)
	);

	bind turn_reporter turn_reporter_asserts u_turn_reporter_asserts (
		.clk           (clk),
		.reset         (reset),
		.send          (send),
		.can_send      (can_send),
		.credit_return (credit_return),
		.report_valid  (report_valid),
		.credits       (credits)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic draw(input int range, output int value);
		rng_state = xorshift32(rng_state);
		value = int'(rng_state % range);
	endtask

	task automatic check_value(input string what, input int got, input int expected);
		checks++;
		if (got != expected) begin
			errors++;
			$display("error at %0d ns: %s is %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	function automatic bit is_penalty(input int s);
		return (s == 2) || (s == 30);
	endfunction

	function automatic bit is_bonus(input int s);
		return (s == 4) || (s == 12) || (s == 20) || (s == 28);
	endfunction

	function automatic bit is_neutral(input int s);
		return (s == 0) || (s == 8);
	endfunction

	function automatic bit is_flat(input int s);
		return (s == 16) || (s == 24);
	endfunction

	// one turn of the rules, queues the report it should produce
	task automatic model_turn(input int p, input int a, input int b);
		int s;
		int big;
		int sc;
		s   = (m_spot[p] + a + b) % game_rules_pkg::BOARD_SPOTS;
		big = (a > b) ? a : b;
		sc  = m_score[p];
		if (is_penalty(s)) begin
			sc = sc - big * int'(game_rules_pkg::PENALTY_BASE);
			if (sc < 0)
				sc = 0;
		end else if (is_bonus(s)) begin
			sc = sc + big * int'(game_rules_pkg::BONUS_BASE);
		end else if (!is_neutral(s) && prop_mask[s] && !m_prog[p][s]) begin
			m_prog[p][s] = 1'b1;
			if (is_flat(s))
				sc = sc + int'(game_rules_pkg::SPOT_SCORE[s]);
			else
				sc = sc + int'(game_rules_pkg::SPOT_SCORE[s]) * big;
		end
		if (sc > SCORE_MAX)
			sc = SCORE_MAX;
		m_spot[p]  = s;
		m_score[p] = sc;
		m_fin[p]   = ((m_prog[p] & prop_mask) == prop_mask);
		exp_player.push_back(p);
		exp_spot.push_back(s);
		exp_score.push_back(sc);
	endtask

	// -1 when every player has finished
	function automatic int pick_next(input int p, input bit dbl);
		int q;
		if (dbl && !m_fin[p])
			return p;
		for (int i = 1; i <= NP; i++) begin
			q = (p + i) % NP;
			if (!m_fin[q])
				return q;
		end
		return -1;
	endfunction

	task automatic wait_report(input int target, output bit ok);
		int n;
		n = 0;
		while (n < WAIT_LIMIT && rpt_count < target) begin
			@(posedge clk);
			#1;
			n++;
		end
		ok = (rpt_count >= target);
	endtask

	task automatic wait_roll_or_over(output bit ok);
		int n;
		n  = 0;
		ok = 1'b0;
		while (n < 20 && !ok) begin
			@(posedge clk);
			#1;
			ok = roll_ready || game_over;
			n++;
		end
	endtask

	// report checker and consumer buffer
	always @(negedge clk) begin : report_monitor
		int delay;
		if (reset) begin
			if (turn_open)
				check_value("roll_ready during an open turn", roll_ready, 0);
			check_value("report_valid on two cycles in a row", int'(report_valid && last_valid), 0);
			if (report_valid) begin
				if (exp_player.size() == 0) begin
					errors++;
					$display("report from player %0d arrived with no turn pending", report_player);
				end else begin
					check_value("report_player", report_player, exp_player.pop_front());
					check_value("report_spot", report_spot, exp_spot.pop_front());
					check_value("report_score", report_score, exp_score.pop_front());
				end
				rpt_count++;
				rpt_cycle = cycle;
				turn_open = 1'b0;
				outstanding++;
				check_value("unreturned reports within credit limit",
					int'(outstanding <= game_ctrl_pkg::REPORT_CREDITS), 1);
				// long hold-back stretches starve the reporter of credit
				if ((rpt_count / 40) % 4 == 1) begin
					draw(40, delay);
					delay = delay + 50;
				end else begin
					draw(21, delay);
				end
				credit_due.push_back(cycle + delay);
			end
			last_valid = report_valid;
		end
	end

	initial begin : credit_consumer
		credit_return = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			credit_return = 1'b0;
			if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
				void'(credit_due.pop_front());
				credit_return = 1'b1;
				outstanding--;
			end
		end
	end

	initial begin : driver
		int a;
		int b;
		int f;
		int gap;
		int rate;
		int latency;
		int nxt;
		int acc_cycle;
		int turns;
		int base;
		bit fst;
		bit ok;
		bit done;
		reset       = 1'b0;
		roll        = 1'b0;
		d1          = 3'd1;
		d2          = 3'd1;
		fast_fwd    = 1'b0;
		rng_state   = 32'hc51797ac;
		cycle       = 0;
		errors      = 0;
		checks      = 0;
		timeouts    = 0;
		rpt_count   = 0;
		rpt_cycle   = 0;
		outstanding = 0;
		turn_open   = 1'b0;
		last_valid  = 1'b0;
		m_player    = 0;
		for (int p = 0; p < NP; p++) begin
			m_spot[p]  = 0;
			m_score[p] = 0;
			m_prog[p]  = '0;
			m_fin[p]   = 1'b0;
		end
		// properties are the scoring spots other than penalty and bonus
		for (int s = 0; s < game_rules_pkg::BOARD_SPOTS; s++)
			prop_mask[s] = (game_rules_pkg::SPOT_SCORE[s] != 0) && !is_penalty(s) && !is_bonus(s);

		repeat (8) @(posedge clk);
		#1;
		reset = 1'b1;
		check_value("roll_ready at reset release", roll_ready, 0);
		check_value("game_over after reset", game_over, 0);
		check_value("report_valid after reset", report_valid, 0);
		check_value("turn_player after reset", turn_player, 0);
		@(posedge clk);
		#1;
		check_value("roll_ready one cycle after reset", roll_ready, 1);

		done  = 1'b0;
		ok    = 1'b1;
		turns = 0;
		while (!done && ok && turns < MAX_TURNS) begin
			draw(4, gap);
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
			check_value("roll_ready before roll", roll_ready, 1);
			check_value("turn_player", turn_player, m_player);
			draw(6, a);
			draw(6, b);
			draw(8, f);
			a        = a + 1;
			b        = b + 1;
			fst      = (f != 0);
			roll     = 1'b1;
			d1       = game_rules_pkg::die_t'(a);
			d2       = game_rules_pkg::die_t'(b);
			fast_fwd = fst;
			model_turn(m_player, a, b);
			@(posedge clk);
			#1;
			roll      = 1'b0;
			acc_cycle = cycle;
			turn_open = 1'b1;
			turns++;
			wait_report(turns, ok);
			if (!ok) begin
				timeouts++;
				$display("no report arrived for turn %0d", turns);
			end else begin
				latency = rpt_cycle - acc_cycle;
				rate    = fst ? game_ctrl_pkg::FAST_STEP_CYCLES : game_ctrl_pkg::STEP_CYCLES;
				check_value("turn latency covers all steps", int'(latency >= (a + b) * rate), 1);
				nxt = pick_next(m_player, a == b);
				wait_roll_or_over(ok);
				if (!ok) begin
					timeouts++;
					$display("neither roll_ready nor game_over rose after turn %0d", turns);
				end else begin
					check_value("game_over after turn", game_over, int'(nxt < 0));
					if (nxt < 0)
						done = 1'b1;
					else
						m_player = nxt;
				end
			end
		end

		if (!done && ok) begin
			timeouts++;
			$display("game still running after %0d turns", MAX_TURNS);
		end
		if (done) begin
			// controller must stay quiet once the game is over
			base = rpt_count;
			repeat (40) begin
				@(posedge clk);
				#1;
				check_value("roll_ready after game_over", roll_ready, 0);
				check_value("game_over held", game_over, 1);
			end
			check_value("reports after game_over", rpt_count, base);
			check_value("expected reports left over", exp_player.size(), 0);
		end

		$display("turns %0d, checks %0d, errors %0d, timeouts %0d",
			turns, checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- board_game_ctrl.f
src/game_rules_pkg.sv
src/game_ctrl_pkg.sv
src/step_timer.sv
src/player_bank.sv
src/score_calc.sv
src/turn_reporter.sv
src/game_fsm.sv
src/board_game_ctrl.sv
dv/turn_reporter_asserts.sv
dv/tb_board_game.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --timing --assert -Wno-fatal
TOP       := tb_board_game
FILELIST  := board_game_ctrl.f
BUILD_DIR := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
